// ==== hdl/dma_cfg.svh ====
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// DRAM side
`define DMA_WORD_W 32
`define DMA_DRAM_ADDR_W 32
`define DMA_ROW_W 12
`define DMA_COL_W 10
`define DMA_CAS_LATENCY 4

// SRAM side
`define DMA_LINE_ADDR_W 7
`define DMA_IN_WORDS 4

// one 3x3 kernel per weight line
`define DMA_WGT_WORDS 9
`define DMA_WGT_BANKS 32

`endif

// ==== hdl/dma_pkg.sv ====
`include "dma_cfg.svh"

package dma_pkg;

	typedef logic [`DMA_WORD_W-1:0] word_t;
	typedef logic [`DMA_DRAM_ADDR_W-1:0] dram_addr_t;
	typedef logic [`DMA_ROW_W-1:0] dram_a_t;
	typedef logic [`DMA_LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [`DMA_IN_WORDS*`DMA_WORD_W-1:0] in_line_t;
	typedef logic [`DMA_WGT_WORDS*`DMA_WORD_W-1:0] wgt_line_t;
	typedef logic [$clog2(`DMA_WGT_BANKS)-1:0] bank_t;

	typedef enum logic
	{
		tgt_input,
		tgt_weight
	} target_t;

	typedef enum logic [2:0]
	{
		rd_idle,
		rd_activate,
		rd_read,
		rd_precharge,
		rd_drain
	} reader_state_t;

endpackage

// ==== hdl/dram_reader.sv ====
`include "dma_cfg.svh"

module dram_reader
	import dma_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	output logic start_ready,
	input dram_addr_t dram_start_addr,
	input line_addr_t sram_addr_start,
	input line_addr_t sram_addr_end,
	input target_t target,
	output logic dram_ras_n,
	output logic dram_cas_n,
	output dram_a_t dram_a,
	input word_t dram_q,
	output logic word_valid,
	output word_t word
);

	localparam int CNT_W = `DMA_LINE_ADDR_W + 5;
	localparam int COL_LSB = 2;
	localparam int ROW_LSB = COL_LSB + `DMA_COL_W;
	localparam int LAT = `DMA_CAS_LATENCY;

	reader_state_t state;
	reader_state_t state_nxt;
	dram_addr_t addr;
	logic [CNT_W-1:0] remaining;
	logic [CNT_W-1:0] total_reads;
	logic [`DMA_LINE_ADDR_W:0] line_count;
	logic [3:0] words_per_line;
	logic [LAT-1:0] valid_pipe;
	logic accept;
	logic cas_cycle;
	logic last_col;
	logic last_read;

	assign start_ready = (state == rd_idle);
	assign accept = start && start_ready;
	assign cas_cycle = (state == rd_read);

	// read count for the whole transfer
	assign line_count = {1'b0, sram_addr_end} - {1'b0, sram_addr_start}
		+ {{`DMA_LINE_ADDR_W{1'b0}}, 1'b1};
	assign words_per_line = (target == tgt_weight) ? 4'(`DMA_WGT_WORDS) : 4'(`DMA_IN_WORDS);
	assign total_reads = CNT_W'(line_count) * CNT_W'(words_per_line);

	assign last_col = (addr[ROW_LSB-1:COL_LSB] == '1);
	assign last_read = (remaining == CNT_W'(1));

	always_comb
	begin
		state_nxt = state;
		case (state)
			rd_idle:
				if (accept)
					state_nxt = rd_activate;
			rd_activate:
				state_nxt = rd_read;
			rd_read:
				if (last_read)
					state_nxt = rd_drain;
				else if (last_col)
					state_nxt = rd_precharge;
			rd_precharge:
				state_nxt = rd_activate;
			rd_drain:
				// last word leaves the pipe this cycle
				if (valid_pipe[LAT-2:0] == '0)
					state_nxt = rd_idle;
			default:
				state_nxt = rd_idle;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= rd_idle;
			addr <= '0;
			remaining <= '0;
			valid_pipe <= '0;
		end
		else
		begin
			state <= state_nxt;
			valid_pipe <= {valid_pipe[LAT-2:0], cas_cycle};
			if (accept)
			begin
				addr <= dram_start_addr;
				remaining <= total_reads;
			end
			else if (cas_cycle)
			begin
				addr <= addr + dram_addr_t'(4);
				remaining <= remaining - CNT_W'(1);
			end
		end
	end

	// strobes are single-cycle commands
	always_comb
	begin
		dram_ras_n = 1'b1;
		dram_cas_n = 1'b1;
		dram_a = '0;
		case (state)
			rd_activate:
			begin
				dram_ras_n = 1'b0;
				dram_a = addr[ROW_LSB+`DMA_ROW_W-1:ROW_LSB];
			end
			rd_read:
			begin
				dram_cas_n = 1'b0;
				dram_a = dram_a_t'(addr[ROW_LSB-1:COL_LSB]);
			end
			default:
			begin
				dram_a = '0;
			end
		endcase
	end

	// data arrives LAT cycles after its CAS
	assign word_valid = valid_pipe[LAT-1];
	assign word = dram_q;

	a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
		!(!dram_ras_n && !dram_cas_n));

	// drain must flush every read before idle
	a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
		(state == rd_idle) |-> (valid_pipe == '0 && !word_valid));

endmodule

// ==== hdl/word_packer.sv ====
`include "dma_cfg.svh"

module word_packer
	import dma_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic start_ready,
	input target_t target,
	input logic word_valid,
	input word_t word,
	output logic line_valid,
	output wgt_line_t line
);

	localparam int CNT_W = $clog2(`DMA_WGT_WORDS);
	localparam int LINE_W = $bits(wgt_line_t);

	target_t tgt_q;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] last_count;

	assign last_count = (tgt_q == tgt_weight) ? CNT_W'(`DMA_WGT_WORDS - 1)
		: CNT_W'(`DMA_IN_WORDS - 1);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tgt_q <= tgt_input;
			count <= '0;
			line_valid <= 1'b0;
		end
		else
		begin
			line_valid <= 1'b0;
			if (start && start_ready)
			begin
				tgt_q <= target;
				count <= '0;
			end
			else if (word_valid)
			begin
				if (count == last_count)
				begin
					count <= '0;
					line_valid <= 1'b1;
				end
				else
				begin
					count <= count + CNT_W'(1);
				end
			end
		end
	end

	// first word ends up in the top slot of the line
	always_ff @(posedge clk)
	begin
		if (word_valid)
			line <= {line[LINE_W-`DMA_WORD_W-1:0], word};
	end

endmodule

// ==== hdl/sram_writer.sv ====
`include "dma_cfg.svh"

module sram_writer
	import dma_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic start_ready,
	input target_t target,
	input logic buf_select,
	input bank_t weight_bank,
	input line_addr_t sram_addr_start,
	input line_addr_t sram_addr_end,
	input logic line_valid,
	input wgt_line_t line,
	output logic [1:0] in_buf_cen,
	output logic [1:0] in_buf_wen,
	output line_addr_t in_buf_a,
	output in_line_t in_buf_di,
	output logic [`DMA_WGT_BANKS-1:0] wgt_cen,
	output logic [`DMA_WGT_BANKS-1:0] wgt_wen,
	output line_addr_t wgt_a,
	output wgt_line_t wgt_di,
	output logic done
);

	target_t tgt_q;
	logic sel_q;
	bank_t bank_q;
	line_addr_t addr_q;
	line_addr_t end_q;
	logic last_q;
	logic [1:0] in_sel;
	logic [`DMA_WGT_BANKS-1:0] wgt_sel;

	// one-hot select of the destination for this line
	assign in_sel = (line_valid && tgt_q == tgt_input) ? (2'b01 << sel_q) : 2'b00;
	assign wgt_sel = (line_valid && tgt_q == tgt_weight)
		? ({{(`DMA_WGT_BANKS-1){1'b0}}, 1'b1} << bank_q) : '0;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tgt_q <= tgt_input;
			sel_q <= 1'b0;
			bank_q <= '0;
			addr_q <= '0;
			end_q <= '0;
			last_q <= 1'b0;
			done <= 1'b0;
			in_buf_cen <= '1;
			in_buf_wen <= '1;
			wgt_cen <= '1;
			wgt_wen <= '1;
		end
		else
		begin
			in_buf_cen <= ~in_sel;
			in_buf_wen <= ~in_sel;
			wgt_cen <= ~wgt_sel;
			wgt_wen <= ~wgt_sel;
			last_q <= line_valid && (addr_q == end_q);
			done <= last_q;
			if (start && start_ready)
			begin
				tgt_q <= target;
				sel_q <= buf_select;
				bank_q <= weight_bank;
				addr_q <= sram_addr_start;
				end_q <= sram_addr_end;
			end
			else if (line_valid)
			begin
				addr_q <= addr_q + line_addr_t'(1);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (line_valid)
		begin
			if (tgt_q == tgt_input)
			begin
				in_buf_a <= addr_q;
				// input lines sit in the low part of the line bus
				in_buf_di <= line[$bits(in_line_t)-1:0];
			end
			else
			begin
				wgt_a <= addr_q;
				wgt_di <= line;
			end
		end
	end

	a_one_dest: assert property (@(posedge clk) disable iff (rst)
		$onehot0(~in_buf_cen) && $onehot0(~wgt_cen));

endmodule

// ==== hdl/dma_loader.sv ====
`include "dma_cfg.svh"

module dma_loader
	import dma_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	output logic start_ready,
	input dram_addr_t dram_start_addr,
	input line_addr_t sram_addr_start,
	input line_addr_t sram_addr_end,
	input target_t target,
	input logic buf_select,
	input bank_t weight_bank,
	output logic dram_ras_n,
	output logic dram_cas_n,
	output dram_a_t dram_a,
	input word_t dram_q,
	output logic [1:0] in_buf_cen,
	output logic [1:0] in_buf_wen,
	output line_addr_t in_buf_a,
	output in_line_t in_buf_di,
	output logic [`DMA_WGT_BANKS-1:0] wgt_cen,
	output logic [`DMA_WGT_BANKS-1:0] wgt_wen,
	output line_addr_t wgt_a,
	output wgt_line_t wgt_di,
	output logic done
);

	logic word_valid;
	word_t word;
	logic line_valid;
	wgt_line_t line;

	dram_reader u_reader (
		.clk(clk),
		.rst(rst),
		.start(start),
		.start_ready(start_ready),
		.dram_start_addr(dram_start_addr),
		.sram_addr_start(sram_addr_start),
		.sram_addr_end(sram_addr_end),
		.target(target),
		.dram_ras_n(dram_ras_n),
		.dram_cas_n(dram_cas_n),
		.dram_a(dram_a),
		.dram_q(dram_q),
		.word_valid(word_valid),
		.word(word)
	);

	word_packer u_packer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.start_ready(start_ready),
		.target(target),
		.word_valid(word_valid),
		.word(word),
		.line_valid(line_valid),
		.line(line)
	);

	sram_writer u_writer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.start_ready(start_ready),
		.target(target),
		.buf_select(buf_select),
		.weight_bank(weight_bank),
		.sram_addr_start(sram_addr_start),
		.sram_addr_end(sram_addr_end),
		.line_valid(line_valid),
		.line(line),
		.in_buf_cen(in_buf_cen),
		.in_buf_wen(in_buf_wen),
		.in_buf_a(in_buf_a),
		.in_buf_di(in_buf_di),
		.wgt_cen(wgt_cen),
		.wgt_wen(wgt_wen),
		.wgt_a(wgt_a),
		.wgt_di(wgt_di),
		.done(done)
	);

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock
(
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset held over the first three rising edges
	initial
	begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== dv/dram_model.sv ====
`include "dma_cfg.svh"

module dram_model
	import dma_pkg::*;
(
	input logic clk,
	input logic ras_n,
	input logic cas_n,
	input dram_a_t a,
	output word_t q
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LAT = `DMA_CAS_LATENCY;
	localparam int MEM_WORDS = 4096;

	// rows 0 to 3 only and indexed by {row[1:0], column}
	word_t mem [MEM_WORDS];
	word_t [LAT-1:0] q_pipe = '0;
	dram_a_t open_row = '0;
	logic row_open = 1'b0;
	logic cas_seen = 1'b0;
	logic [`DMA_COL_W-1:0] last_col = '0;
	int proto_errors = 0;

	always @(posedge clk)
	begin
		word_t rd;
		rd = '0;
		if (!ras_n)
		begin
			open_row <= a;
			row_open <= 1'b1;
			cas_seen <= 1'b0;
		end
		if (!cas_n)
		begin
			if (!row_open)
			begin
				$display("DRAM model: CAS at %0t ns with no open row", $time);
				proto_errors++;
			end
			else if (cas_seen && {1'b0, a[`DMA_COL_W-1:0]} != {1'b0, last_col} + 11'd1)
			begin
				$display("DRAM model: at %0t ns column %0d in row %0d does not follow column %0d",
					$time, a[`DMA_COL_W-1:0], open_row, last_col);
				proto_errors++;
			end
			rd = mem[{open_row[1:0], a[`DMA_COL_W-1:0]}];
			last_col <= a[`DMA_COL_W-1:0];
			cas_seen <= 1'b1;
		end
		q_pipe <= {q_pipe[LAT-2:0], rd};
	end

	assign q = q_pipe[LAT-1];

endmodule

// ==== dv/dma_loader_tb.sv ====
`include "dma_cfg.svh"

module dma_loader_tb
	import dma_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] SEED = 32'h7166a9d1;
	localparam int N_TESTS = 6;
	localparam int MARGIN = 200;
	localparam int MEM_WORDS = 4096;

	logic clk, rst, start, start_ready, buf_select, done;
	logic dram_ras_n, dram_cas_n;
	dram_addr_t dram_start_addr;
	line_addr_t sram_addr_start, sram_addr_end, in_buf_a, wgt_a;
	target_t target;
	bank_t weight_bank;
	dram_a_t dram_a;
	word_t dram_q;
	logic [1:0] in_buf_cen, in_buf_wen;
	in_line_t in_buf_di;
	logic [`DMA_WGT_BANKS-1:0] wgt_cen, wgt_wen;
	wgt_line_t wgt_di;

	// transfer table with sel as the buffer or the bank
	dram_addr_t tbl_addr [N_TESTS];
	target_t tbl_tgt [N_TESTS];
	bank_t tbl_sel [N_TESTS];
	line_addr_t tbl_sa [N_TESTS];
	line_addr_t tbl_ea [N_TESTS];
	logic tbl_poke [N_TESTS];
	int tbl_lines [N_TESTS];

	word_t ref_mem [MEM_WORDS];
	int cur_test = 0;
	int n_writes = 0;
	int n_dones = 0;
	int n_checks = 0;
	int errors = 0;
	int cycles = 0;
	int limit = 0;

	tb_clock u_clock (.clk(clk), .rst(rst));

	dram_model u_dram (.clk(clk), .ras_n(dram_ras_n), .cas_n(dram_cas_n), .a(dram_a), .q(dram_q));

	dma_loader uut (
		.clk(clk), .rst(rst), .start(start), .start_ready(start_ready),
		.dram_start_addr(dram_start_addr), .sram_addr_start(sram_addr_start),
		.sram_addr_end(sram_addr_end), .target(target), .buf_select(buf_select),
		.weight_bank(weight_bank), .dram_ras_n(dram_ras_n), .dram_cas_n(dram_cas_n),
		.dram_a(dram_a), .dram_q(dram_q), .in_buf_cen(in_buf_cen), .in_buf_wen(in_buf_wen),
		.in_buf_a(in_buf_a), .in_buf_di(in_buf_di), .wgt_cen(wgt_cen), .wgt_wen(wgt_wen),
		.wgt_a(wgt_a), .wgt_di(wgt_di), .done(done)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	// first word lands in the top slot of the used part
	function automatic wgt_line_t expected_line(input dram_addr_t addr, input int idx,
		input int words);
		wgt_line_t ln;
		int base;
		ln = '0;
		base = int'(addr >> 2) + idx * words;
		for (int j = 0; j < words; j++)
			ln = {ln[$bits(wgt_line_t)-`DMA_WORD_W-1:0], ref_mem[(base + j) % MEM_WORDS]};
		return ln;
	endfunction

	task automatic check_value(input string what, input logic [287:0] got,
		input logic [287:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic add_entry(input int i, input dram_addr_t addr, input target_t tgt,
		input bank_t sel, input line_addr_t sa, input line_addr_t ea, input logic poke,
		input int lines);
		tbl_addr[i] = addr;
		tbl_tgt[i] = tgt;
		tbl_sel[i] = sel;
		tbl_sa[i] = sa;
		tbl_ea[i] = ea;
		tbl_poke[i] = poke;
		tbl_lines[i] = lines;
	endtask

	task automatic record_write();
		logic [1:0] exp_in;
		logic [`DMA_WGT_BANKS-1:0] exp_wgt;
		line_addr_t exp_a;
		wgt_line_t exp_line;
		exp_in = 2'b11;
		exp_wgt = '1;
		exp_a = tbl_sa[cur_test] + line_addr_t'(n_writes);
		if (n_writes >= tbl_lines[cur_test])
		begin
			errors++;
			$display("%0t ns: test %0d wrote more than %0d lines", $time, cur_test,
				tbl_lines[cur_test]);
		end
		else if (tbl_tgt[cur_test] == tgt_input)
		begin
			exp_in[tbl_sel[cur_test][0]] = 1'b0;
			exp_line = expected_line(tbl_addr[cur_test], n_writes, `DMA_IN_WORDS);
			check_value("in_buf_cen", 288'(in_buf_cen), 288'(exp_in));
			check_value("in_buf_wen", 288'(in_buf_wen), 288'(exp_in));
			check_value("wgt_cen", 288'(wgt_cen), 288'(exp_wgt));
			check_value("wgt_wen", 288'(wgt_wen), 288'(exp_wgt));
			check_value("in_buf_a", 288'(in_buf_a), 288'(exp_a));
			check_value("in_buf_di", 288'(in_buf_di), exp_line);
		end
		else
		begin
			exp_wgt[tbl_sel[cur_test]] = 1'b0;
			exp_line = expected_line(tbl_addr[cur_test], n_writes, `DMA_WGT_WORDS);
			check_value("wgt_cen", 288'(wgt_cen), 288'(exp_wgt));
			check_value("wgt_wen", 288'(wgt_wen), 288'(exp_wgt));
			check_value("in_buf_cen", 288'(in_buf_cen), 288'(exp_in));
			check_value("in_buf_wen", 288'(in_buf_wen), 288'(exp_in));
			check_value("wgt_a", 288'(wgt_a), 288'(exp_a));
			check_value("wgt_di", 288'(wgt_di), exp_line);
		end
		n_writes++;
	endtask

	// write and done monitor
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (in_buf_cen != 2'b11 || wgt_cen != '1 || in_buf_wen != 2'b11 || wgt_wen != '1)
				record_write();
			if (done)
			begin
				n_dones++;
				check_value("writes before done", 288'(n_writes), 288'(tbl_lines[cur_test]));
			end
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit)
		begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	initial
	begin
		logic [31:0] x;
		int words, reads, crossings, err_before, proto_before;
		start <= 1'b0;
		dram_start_addr <= '0;
		sram_addr_start <= '0;
		sram_addr_end <= '0;
		target <= tgt_input;
		buf_select <= 1'b0;
		weight_bank <= '0;
		x = SEED;
		for (int i = 0; i < MEM_WORDS; i++)
		begin
			x = xorshift32(x);
			ref_mem[i] = x;
			u_dram.mem[i] = x;
		end
		add_entry(0, 32'h0000_0040, tgt_input, 5'd0, 7'd5, 7'd12, 1'b0, 8);
		add_entry(1, 32'h0000_1100, tgt_input, 5'd1, 7'd0, 7'd3, 1'b1, 4);
		add_entry(2, 32'h0000_2200, tgt_weight, 5'd7, 7'd10, 7'd13, 1'b0, 4);
		// column 1020 so the load crosses into row 1
		add_entry(3, 32'h0000_0ff0, tgt_input, 5'd0, 7'd20, 7'd23, 1'b0, 4);
		add_entry(4, 32'h0000_1fe8, tgt_weight, 5'd31, 7'd100, 7'd102, 1'b0, 3);
		add_entry(5, 32'h0000_3000, tgt_weight, 5'd0, 7'd127, 7'd127, 1'b0, 1);
		for (int t = 0; t < N_TESTS; t++)
		begin
			words = (tbl_tgt[t] == tgt_weight) ? `DMA_WGT_WORDS : `DMA_IN_WORDS;
			reads = tbl_lines[t] * words;
			crossings = (int'(tbl_addr[t][11:2]) + reads - 1) / 1024;
			limit += reads + crossings * 4;
		end
		limit += MARGIN;

		@(negedge clk);
		while (rst)
			@(negedge clk);
		check_value("in_buf_cen after reset", 288'(in_buf_cen), 288'(2'b11));
		check_value("in_buf_wen after reset", 288'(in_buf_wen), 288'(2'b11));
		check_value("wgt_cen after reset", 288'(wgt_cen), 288'({`DMA_WGT_BANKS{1'b1}}));
		check_value("wgt_wen after reset", 288'(wgt_wen), 288'({`DMA_WGT_BANKS{1'b1}}));
		check_value("dram strobes after reset", 288'({dram_ras_n, dram_cas_n}), 288'(2'b11));
		check_value("done after reset", 288'(done), 288'(1'b0));
		check_value("start_ready after reset", 288'(start_ready), 288'(1'b1));
		$display("reset state: %0d errors", errors);

		for (int t = 0; t < N_TESTS; t++)
		begin
			err_before = errors;
			proto_before = u_dram.proto_errors;
			@(posedge clk);
			cur_test = t;
			n_writes = 0;
			n_dones = 0;
			start <= 1'b1;
			dram_start_addr <= tbl_addr[t];
			sram_addr_start <= tbl_sa[t];
			sram_addr_end <= tbl_ea[t];
			target <= tbl_tgt[t];
			buf_select <= tbl_sel[t][0];
			weight_bank <= tbl_sel[t];
			@(negedge clk);
			while (!start_ready)
				@(negedge clk);
			@(posedge clk);
			// keep start up until lines are being written
			if (tbl_poke[t])
				while (n_writes == 0)
					@(posedge clk);
			start <= 1'b0;
			while (n_dones == 0)
				@(negedge clk);
			repeat (8) @(negedge clk);
			check_value("write count", 288'(n_writes), 288'(tbl_lines[t]));
			check_value("done pulses", 288'(n_dones), 288'(1));
			$display("test %0d: %0d lines, %0d done pulses, %s", t, n_writes, n_dones,
				(errors == err_before && u_dram.proto_errors == proto_before) ? "ok" : "errors");
		end

		$display("%0d tests, %0d checks, %0d errors, %0d DRAM protocol errors", N_TESTS,
			n_checks, errors, u_dram.proto_errors);
		if (errors == 0 && u_dram.proto_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== dma_loader.f ====
+incdir+hdl
hdl/dma_pkg.sv
hdl/dram_reader.sv
hdl/word_packer.sv
hdl/sram_writer.sv
hdl/dma_loader.sv
dv/tb_clock.sv
dv/dram_model.sv
dv/dma_loader_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vdma_loader_tb
SRCS = hdl/dma_cfg.svh hdl/dma_pkg.sv hdl/dram_reader.sv hdl/word_packer.sv \
	hdl/sram_writer.sv hdl/dma_loader.sv dv/tb_clock.sv dv/dram_model.sv \
	dv/dma_loader_tb.sv

.PHONY: all run clean

all: run

$(SIM): dma_loader.f $(SRCS)
	verilator --binary --assert --timescale 1ns/100ps --top-module dma_loader_tb \
		-Mdir obj_dir -f dma_loader.f

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
